// ==== cnn_axi_bridge.f ====
rtl/cnn_axi_pkg.sv
rtl/cnn_axi_if.sv
rtl/cnn_axi_rd_bridge.sv
rtl/cnn_axi_wr_bridge.sv
rtl/cnn_axi_bridge.sv
testbench/cnn_axi_bridge_props.sv
testbench/tb_cnn_axi_bridge.sv

// ==== Makefile ====
TOP = tb_cnn_axi_bridge

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f cnn_axi_bridge.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100

lint:
	verilator --lint-only --timing rtl/cnn_axi_pkg.sv rtl/cnn_axi_if.sv \
		rtl/cnn_axi_rd_bridge.sv rtl/cnn_axi_wr_bridge.sv rtl/cnn_axi_bridge.sv \
		--top-module cnn_axi_bridge

clean:
	rm -rf obj_dir

// ==== testbench/tb_cnn_axi_bridge.sv ====
bind cnn_axi_bridge cnn_axi_bridge_props u_props (.*);

module tb_cnn_axi_bridge;

    localparam int NR = cnn_axi_pkg::NUM_RD_CLIENTS;
    localparam int NW = cnn_axi_pkg::NUM_WR_CLIENTS;
    // 3 bursts of up to 8 beats per client with about half the cycles stalled
    localparam int MAX_CYCLES = 2000;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic [NR-1:0] rd_req, rd_req_ack, rd_data_vld, rd_data_rdy, rd_cmpl;
    logic [NR-1:0] axi_arvalid, axi_arready, axi_rvalid, axi_rlast, axi_rready;
    cnn_axi_pkg::id_t   rd_id [NR], axi_arid [NR];
    cnn_axi_pkg::addr_t rd_addr [NR], axi_araddr [NR];
    cnn_axi_pkg::len_t  rd_len [NR], axi_arlen [NR];
    cnn_axi_pkg::data_t rd_data [NR], axi_rdata [NR];
    logic [NW-1:0] wr_req, wr_req_ack, wr_data_vld, wr_data_rdy, wr_cmpl;
    logic [NW-1:0] axi_awvalid, axi_awready, axi_wvalid, axi_wlast, axi_wready, axi_bvalid;
    cnn_axi_pkg::id_t   wr_id [NW], axi_awid [NW];
    cnn_axi_pkg::addr_t wr_addr [NW], axi_awaddr [NW];
    cnn_axi_pkg::len_t  wr_len [NW], axi_awlen [NW];
    cnn_axi_pkg::data_t wr_data [NW], axi_wdata [NW];
    int unsigned cycles = 0;

    cnn_axi_bridge DUT (.*);

    always #10 clk = ~clk;

    ////////////////////
    // Watchdogs
    ////////////////////
    always @(posedge clk) begin
        cycles++;
        if (DUT.u_props.fail_cnt != 0) begin
            $display("Result: FAILED");
            $fatal(1, "An assertion on the bridge failed");
        end else if (cycles >= MAX_CYCLES) begin
            $display("Result: FAILED");
            $fatal(1, "Timeout, the bursts did not finish within %0d cycles", MAX_CYCLES);
        end
    end

    // Random ready stalls on every channel once out of reset
    always @(posedge clk) begin
        if (!rst) begin
            #1;
            axi_arready = NR'($urandom);
            axi_awready = NW'($urandom);
            axi_wready  = NW'($urandom);
            rd_data_rdy = NR'($urandom);
        end
    end

    ////////////////////
    // Read side
    ////////////////////
    task automatic read_client(input int c);
        for (int n = 0; n < 3; n++) begin
            rd_req[c]  = 1'b1;
            rd_addr[c] = cnn_axi_pkg::addr_t'($urandom);
            rd_id[c]   = cnn_axi_pkg::id_t'(n);
            rd_len[c]  = cnn_axi_pkg::len_t'($urandom_range(0, 7));  // 1 to 8 beats
            @(posedge clk);
            while (!rd_req_ack[c]) @(posedge clk);
            #1 rd_req[c] = 1'b0;
            while (!rd_cmpl[c]) @(posedge clk);  // Pulse after the last beat
            #1;
        end
    endtask

    // Slave returns one burst per accepted AR
    task automatic read_slave(input int c);
        cnn_axi_pkg::len_t len;
        for (int n = 0; n < 3; n++) begin
            @(posedge clk);
            while (!(axi_arvalid[c] && axi_arready[c])) @(posedge clk);
            len = axi_arlen[c];
            for (int b = 0; b <= int'(len); b++) begin
                #1;
                axi_rvalid[c] = 1'b1;
                axi_rdata[c]  = {$urandom, $urandom};
                axi_rlast[c]  = (b == int'(len));
                @(posedge clk);
                while (!axi_rready[c]) @(posedge clk);
            end
            #1 axi_rvalid[c] = 1'b0;
            axi_rlast[c] = 1'b0;
        end
    endtask

    ////////////////////
    // Write side
    ////////////////////
    task automatic write_client(input int c);
        for (int n = 0; n < 3; n++) begin
            wr_req[c]  = 1'b1;
            wr_addr[c] = cnn_axi_pkg::addr_t'($urandom);
            wr_id[c]   = cnn_axi_pkg::id_t'(n);
            wr_len[c]  = cnn_axi_pkg::len_t'($urandom_range(0, 7));
            @(posedge clk);
            while (!wr_req_ack[c]) @(posedge clk);
            #1 wr_req[c] = 1'b0;
            for (int b = 0; b <= int'(wr_len[c]); b++) begin
                wr_data_vld[c] = 1'b1;
                wr_data[c]     = {$urandom, $urandom};
                @(posedge clk);
                while (!wr_data_rdy[c]) @(posedge clk);
                #1;
            end
            wr_data_vld[c] = 1'b0;
            @(posedge clk);
            while (!wr_cmpl[c]) @(posedge clk);
            #1;
        end
    endtask

    // One bvalid cycle after each wlast beat
    task automatic write_slave(input int c);
        for (int n = 0; n < 3; n++) begin
            @(posedge clk);
            while (!(axi_wvalid[c] && axi_wready[c] && axi_wlast[c])) @(posedge clk);
            #1 axi_bvalid[c] = 1'b1;
            @(posedge clk);
            #1 axi_bvalid[c] = 1'b0;
        end
    endtask

    initial begin
        void'($urandom(32'h51b2));
        // Busy last beats and AW transfers while reset is held
        rd_req      = '0;
        rd_data_rdy = '1;
        axi_arready = '0;
        axi_rvalid  = '1;
        axi_rlast   = '1;
        wr_req      = '1;
        wr_data_vld = '0;
        axi_awready = '1;
        axi_wready  = '0;
        axi_bvalid  = '0;
        for (int i = 0; i < NR; i++) begin
            rd_id[i] = '0;
            rd_addr[i] = '0;
            rd_len[i] = '0;
            axi_rdata[i] = '0;
        end
        for (int i = 0; i < NW; i++) begin
            wr_id[i] = '0;
            wr_addr[i] = '0;
            wr_len[i] = '0;
            wr_data[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst         = 1'b0;
        rd_data_rdy = '0;
        axi_rvalid  = '0;
        axi_rlast   = '0;
        wr_req      = '0;
        axi_awready = '0;
        for (int c = 0; c < NR; c++) begin
            automatic int k = c;
            fork
                read_client(k);
                read_slave(k);
            join_none
        end
        for (int c = 0; c < NW; c++) begin
            automatic int k = c;
            fork
                write_client(k);
                write_slave(k);
            join_none
        end
        wait fork;
        repeat (3) @(posedge clk);
        #1;
        if (DUT.u_props.fail_cnt == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("Result: FAILED");
            $fatal(1, "Assertions failed during the run");
        end
    end

endmodule

// ==== testbench/cnn_axi_bridge_props.sv ====
module cnn_axi_bridge_props (
    input logic                                   clk,
    input logic                                   rst,
    input logic [cnn_axi_pkg::NUM_RD_CLIENTS-1:0] rd_req,
    input cnn_axi_pkg::id_t                       rd_id       [cnn_axi_pkg::NUM_RD_CLIENTS],
    input cnn_axi_pkg::addr_t                     rd_addr     [cnn_axi_pkg::NUM_RD_CLIENTS],
    input cnn_axi_pkg::len_t                      rd_len      [cnn_axi_pkg::NUM_RD_CLIENTS],
    input logic [cnn_axi_pkg::NUM_RD_CLIENTS-1:0] rd_req_ack,
    input cnn_axi_pkg::data_t                     rd_data     [cnn_axi_pkg::NUM_RD_CLIENTS],
    input logic [cnn_axi_pkg::NUM_RD_CLIENTS-1:0] rd_data_vld,
    input logic [cnn_axi_pkg::NUM_RD_CLIENTS-1:0] rd_data_rdy,
    input logic [cnn_axi_pkg::NUM_RD_CLIENTS-1:0] rd_cmpl,
    input logic [cnn_axi_pkg::NUM_RD_CLIENTS-1:0] axi_arvalid,
    input cnn_axi_pkg::addr_t                     axi_araddr  [cnn_axi_pkg::NUM_RD_CLIENTS],
    input cnn_axi_pkg::id_t                       axi_arid    [cnn_axi_pkg::NUM_RD_CLIENTS],
    input cnn_axi_pkg::len_t                      axi_arlen   [cnn_axi_pkg::NUM_RD_CLIENTS],
    input logic [cnn_axi_pkg::NUM_RD_CLIENTS-1:0] axi_arready,
    input logic [cnn_axi_pkg::NUM_RD_CLIENTS-1:0] axi_rvalid,
    input cnn_axi_pkg::data_t                     axi_rdata   [cnn_axi_pkg::NUM_RD_CLIENTS],
    input logic [cnn_axi_pkg::NUM_RD_CLIENTS-1:0] axi_rlast,
    input logic [cnn_axi_pkg::NUM_RD_CLIENTS-1:0] axi_rready,
    input logic [cnn_axi_pkg::NUM_WR_CLIENTS-1:0] wr_req,
    input cnn_axi_pkg::id_t                       wr_id       [cnn_axi_pkg::NUM_WR_CLIENTS],
    input cnn_axi_pkg::addr_t                     wr_addr     [cnn_axi_pkg::NUM_WR_CLIENTS],
    input cnn_axi_pkg::len_t                      wr_len      [cnn_axi_pkg::NUM_WR_CLIENTS],
    input logic [cnn_axi_pkg::NUM_WR_CLIENTS-1:0] wr_req_ack,
    input cnn_axi_pkg::data_t                     wr_data     [cnn_axi_pkg::NUM_WR_CLIENTS],
    input logic [cnn_axi_pkg::NUM_WR_CLIENTS-1:0] wr_data_vld,
    input logic [cnn_axi_pkg::NUM_WR_CLIENTS-1:0] wr_data_rdy,
    input logic [cnn_axi_pkg::NUM_WR_CLIENTS-1:0] wr_cmpl,
    input logic [cnn_axi_pkg::NUM_WR_CLIENTS-1:0] axi_awvalid,
    input cnn_axi_pkg::addr_t                     axi_awaddr  [cnn_axi_pkg::NUM_WR_CLIENTS],
    input cnn_axi_pkg::id_t                       axi_awid    [cnn_axi_pkg::NUM_WR_CLIENTS],
    input cnn_axi_pkg::len_t                      axi_awlen   [cnn_axi_pkg::NUM_WR_CLIENTS],
    input logic [cnn_axi_pkg::NUM_WR_CLIENTS-1:0] axi_awready,
    input logic [cnn_axi_pkg::NUM_WR_CLIENTS-1:0] axi_wvalid,
    input cnn_axi_pkg::data_t                     axi_wdata   [cnn_axi_pkg::NUM_WR_CLIENTS],
    input logic [cnn_axi_pkg::NUM_WR_CLIENTS-1:0] axi_wlast,
    input logic [cnn_axi_pkg::NUM_WR_CLIENTS-1:0] axi_wready,
    input logic [cnn_axi_pkg::NUM_WR_CLIENTS-1:0] axi_bvalid
);

    int unsigned fail_cnt = 0;     // Failed assertions so far
    logic        rst_seen = 1'b0;  // Outputs are known from here on
    logic        rst_q    = 1'b0;  // Cycle after a reset cycle

    always_ff @(posedge clk) begin
        rst_q <= rst;
        if (rst) begin
            rst_seen <= 1'b1;
        end
    end

    ////////////////////
    // Read clients
    ////////////////////
    for (genvar i = 0; i < cnn_axi_pkg::NUM_RD_CLIENTS; i++) begin : g_rd
        logic last_q;  // Expected completion pulse

        always_ff @(posedge clk) begin
            last_q <= rst ? 1'b0 : (axi_rvalid[i] & rd_data_rdy[i] & axi_rlast[i]);
        end

        a_ar: assert property (@(posedge clk) rst_seen |->
            axi_arvalid[i] == rd_req[i] && axi_araddr[i] == rd_addr[i] &&
            axi_arid[i] == rd_id[i] && axi_arlen[i] == rd_len[i])
            else begin
                fail_cnt++;
                $error("FAIL ar_map client %0d expected %h actual %h", i,
                    {rd_req[i], rd_id[i], rd_len[i], rd_addr[i]},
                    {axi_arvalid[i], axi_arid[i], axi_arlen[i], axi_araddr[i]});
            end
        a_ar_ack: assert property (@(posedge clk) rst_seen |->
            rd_req_ack[i] == (rd_req[i] & axi_arready[i]))
            else begin
                fail_cnt++;
                $error("FAIL ar_ack client %0d expected %b actual %b",
                    i, rd_req[i] & axi_arready[i], rd_req_ack[i]);
            end
        a_r: assert property (@(posedge clk) rst_seen |->
            rd_data[i] == axi_rdata[i] && rd_data_vld[i] == axi_rvalid[i] &&
            axi_rready[i] == rd_data_rdy[i])
            else begin
                fail_cnt++;
                $error("FAIL r_pass client %0d expected %h actual %h", i,
                    {rd_data_rdy[i], axi_rvalid[i], axi_rdata[i]},
                    {axi_rready[i], rd_data_vld[i], rd_data[i]});
            end
        a_cmpl: assert property (@(posedge clk) rst_seen |-> rd_cmpl[i] == last_q)
            else begin
                fail_cnt++;
                $error("FAIL rd_cmpl client %0d expected %b actual %b",
                    i, $sampled(last_q), $sampled(rd_cmpl[i]));
            end
        a_rst: assert property (@(posedge clk) rst_q |-> !rd_cmpl[i])
            else begin
                fail_cnt++;
                $error("rd_cmpl high during or right after reset");
            end
    end

    ////////////////////
    // Write clients
    ////////////////////
    for (genvar i = 0; i < cnn_axi_pkg::NUM_WR_CLIENTS; i++) begin : g_wr
        logic              open;    // AW seen, no response yet
        cnn_axi_pkg::len_t exp_len;
        cnn_axi_pkg::len_t beats;   // Beats since the AW transfer

        always_ff @(posedge clk) begin
            if (rst) begin
                open  <= 1'b0;
                beats <= '0;
            end else if (axi_awvalid[i] && axi_awready[i]) begin
                open    <= 1'b1;
                exp_len <= axi_awlen[i];
                beats   <= '0;
            end else if (axi_bvalid[i]) begin
                open  <= 1'b0;
                beats <= '0;
            end else if (open && axi_wvalid[i] && axi_wready[i]) begin
                beats <= beats + 1'b1;
            end
        end

        a_aw: assert property (@(posedge clk) rst_seen |->
            axi_awvalid[i] == wr_req[i] && axi_awaddr[i] == wr_addr[i] &&
            axi_awid[i] == wr_id[i] && axi_awlen[i] == wr_len[i] &&
            wr_req_ack[i] == (wr_req[i] & axi_awready[i]))
            else begin
                fail_cnt++;
                $error("FAIL aw_map client %0d expected %h actual %h", i,
                    {wr_req[i] & axi_awready[i], wr_req[i], wr_id[i], wr_len[i], wr_addr[i]},
                    {wr_req_ack[i], axi_awvalid[i], axi_awid[i], axi_awlen[i],
                     axi_awaddr[i]});
            end
        a_w: assert property (@(posedge clk) rst_seen |->
            axi_wdata[i] == wr_data[i] && axi_wvalid[i] == wr_data_vld[i] &&
            wr_data_rdy[i] == axi_wready[i])
            else begin
                fail_cnt++;
                $error("FAIL w_pass client %0d expected %h actual %h", i,
                    {axi_wready[i], wr_data_vld[i], wr_data[i]},
                    {wr_data_rdy[i], axi_wvalid[i], axi_wdata[i]});
            end
        a_wlast: assert property (@(posedge clk)
            rst_seen && open && axi_wvalid[i] && axi_wready[i] |->
            axi_wlast[i] == (beats == exp_len))
            else begin
                fail_cnt++;
                $error("FAIL wlast client %0d expected %b actual %b",
                    i, $sampled(beats == exp_len), $sampled(axi_wlast[i]));
            end
        a_bresp: assert property (@(posedge clk) rst_seen |-> wr_cmpl[i] == axi_bvalid[i])
            else begin
                fail_cnt++;
                $error("FAIL wr_cmpl client %0d expected %b actual %b",
                    i, axi_bvalid[i], wr_cmpl[i]);
            end
        a_rst: assert property (@(posedge clk) rst_q |-> !axi_wlast[i])
            else begin
                fail_cnt++;
                $error("wlast high during or right after reset");
            end
    end

endmodule

// ==== rtl/cnn_axi_bridge.sv ====
module cnn_axi_bridge (
    input  logic                                   clk,
    input  logic                                   rst,

    // Read client side
    input  logic [cnn_axi_pkg::NUM_RD_CLIENTS-1:0] rd_req,
    input  cnn_axi_pkg::id_t                       rd_id       [cnn_axi_pkg::NUM_RD_CLIENTS],
    input  cnn_axi_pkg::addr_t                     rd_addr     [cnn_axi_pkg::NUM_RD_CLIENTS],
    input  cnn_axi_pkg::len_t                      rd_len      [cnn_axi_pkg::NUM_RD_CLIENTS],
    output logic [cnn_axi_pkg::NUM_RD_CLIENTS-1:0] rd_req_ack,
    output cnn_axi_pkg::data_t                     rd_data     [cnn_axi_pkg::NUM_RD_CLIENTS],
    output logic [cnn_axi_pkg::NUM_RD_CLIENTS-1:0] rd_data_vld,
    input  logic [cnn_axi_pkg::NUM_RD_CLIENTS-1:0] rd_data_rdy,
    output logic [cnn_axi_pkg::NUM_RD_CLIENTS-1:0] rd_cmpl,

    // Read AXI side
    output logic [cnn_axi_pkg::NUM_RD_CLIENTS-1:0] axi_arvalid,
    output cnn_axi_pkg::addr_t                     axi_araddr  [cnn_axi_pkg::NUM_RD_CLIENTS],
    output cnn_axi_pkg::id_t                       axi_arid    [cnn_axi_pkg::NUM_RD_CLIENTS],
    output cnn_axi_pkg::len_t                      axi_arlen   [cnn_axi_pkg::NUM_RD_CLIENTS],
    input  logic [cnn_axi_pkg::NUM_RD_CLIENTS-1:0] axi_arready,
    input  logic [cnn_axi_pkg::NUM_RD_CLIENTS-1:0] axi_rvalid,
    input  cnn_axi_pkg::data_t                     axi_rdata   [cnn_axi_pkg::NUM_RD_CLIENTS],
    input  logic [cnn_axi_pkg::NUM_RD_CLIENTS-1:0] axi_rlast,
    output logic [cnn_axi_pkg::NUM_RD_CLIENTS-1:0] axi_rready,

    // Write client side
    input  logic [cnn_axi_pkg::NUM_WR_CLIENTS-1:0] wr_req,
    input  cnn_axi_pkg::id_t                       wr_id       [cnn_axi_pkg::NUM_WR_CLIENTS],
    input  cnn_axi_pkg::addr_t                     wr_addr     [cnn_axi_pkg::NUM_WR_CLIENTS],
    input  cnn_axi_pkg::len_t                      wr_len      [cnn_axi_pkg::NUM_WR_CLIENTS],
    output logic [cnn_axi_pkg::NUM_WR_CLIENTS-1:0] wr_req_ack,
    input  cnn_axi_pkg::data_t                     wr_data     [cnn_axi_pkg::NUM_WR_CLIENTS],
    input  logic [cnn_axi_pkg::NUM_WR_CLIENTS-1:0] wr_data_vld,
    output logic [cnn_axi_pkg::NUM_WR_CLIENTS-1:0] wr_data_rdy,
    output logic [cnn_axi_pkg::NUM_WR_CLIENTS-1:0] wr_cmpl,

    // Write AXI side
    output logic [cnn_axi_pkg::NUM_WR_CLIENTS-1:0] axi_awvalid,
    output cnn_axi_pkg::addr_t                     axi_awaddr  [cnn_axi_pkg::NUM_WR_CLIENTS],
    output cnn_axi_pkg::id_t                       axi_awid    [cnn_axi_pkg::NUM_WR_CLIENTS],
    output cnn_axi_pkg::len_t                      axi_awlen   [cnn_axi_pkg::NUM_WR_CLIENTS],
    input  logic [cnn_axi_pkg::NUM_WR_CLIENTS-1:0] axi_awready,
    output logic [cnn_axi_pkg::NUM_WR_CLIENTS-1:0] axi_wvalid,
    output cnn_axi_pkg::data_t                     axi_wdata   [cnn_axi_pkg::NUM_WR_CLIENTS],
    output logic [cnn_axi_pkg::NUM_WR_CLIENTS-1:0] axi_wlast,
    input  logic [cnn_axi_pkg::NUM_WR_CLIENTS-1:0] axi_wready,
    input  logic [cnn_axi_pkg::NUM_WR_CLIENTS-1:0] axi_bvalid
);

    axi_rd_if rd_if [cnn_axi_pkg::NUM_RD_CLIENTS] ();   // One channel set per read client
    axi_wr_if wr_if [cnn_axi_pkg::NUM_WR_CLIENTS] ();   // One channel set per write client

    ////////////////////
    // Read clients
    ////////////////////
    for (genvar i = 0; i < cnn_axi_pkg::NUM_RD_CLIENTS; i++) begin : g_rd
        // AR request goes out as is
        assign rd_if[i].arvalid = rd_req[i];
        assign rd_if[i].araddr  = rd_addr[i];
        assign rd_if[i].arid    = rd_id[i];
        assign rd_if[i].arlen   = rd_len[i];
        assign rd_if[i].arready = axi_arready[i];

        assign axi_arvalid[i] = rd_if[i].arvalid;
        assign axi_araddr[i]  = rd_if[i].araddr;
        assign axi_arid[i]    = rd_if[i].arid;
        assign axi_arlen[i]   = rd_if[i].arlen;
        assign rd_req_ack[i]  = rd_if[i].arvalid & rd_if[i].arready;  // Same cycle ack

        // R beats back to the client
        assign rd_if[i].rvalid = axi_rvalid[i];
        assign rd_if[i].rdata  = axi_rdata[i];
        assign rd_if[i].rlast  = axi_rlast[i];
        assign rd_if[i].rready = rd_data_rdy[i];   // Client stalls the slave directly

        assign rd_data[i]     = rd_if[i].rdata;
        assign rd_data_vld[i] = rd_if[i].rvalid;
        assign axi_rready[i]  = rd_if[i].rready;
    end

    cnn_axi_rd_bridge u_rd_bridge (
        .clk     (clk),
        .rst     (rst),
        .rd      (rd_if),
        .rd_cmpl (rd_cmpl)
    );

    ////////////////////
    // Write clients
    ////////////////////
    for (genvar i = 0; i < cnn_axi_pkg::NUM_WR_CLIENTS; i++) begin : g_wr
        // AW request
        assign wr_if[i].awvalid = wr_req[i];
        assign wr_if[i].awaddr  = wr_addr[i];
        assign wr_if[i].awid    = wr_id[i];
        assign wr_if[i].awlen   = wr_len[i];
        assign wr_if[i].awready = axi_awready[i];

        assign axi_awvalid[i] = wr_if[i].awvalid;
        assign axi_awaddr[i]  = wr_if[i].awaddr;
        assign axi_awid[i]    = wr_if[i].awid;
        assign axi_awlen[i]   = wr_if[i].awlen;
        assign wr_req_ack[i]  = wr_if[i].awvalid & wr_if[i].awready;

        // W beats, wlast comes from the tracker
        assign wr_if[i].wvalid = wr_data_vld[i];
        assign wr_if[i].wdata  = wr_data[i];
        assign wr_if[i].wready = axi_wready[i];
        assign wr_if[i].bvalid = axi_bvalid[i];

        assign axi_wvalid[i]  = wr_if[i].wvalid;
        assign axi_wdata[i]   = wr_if[i].wdata;
        assign axi_wlast[i]   = wr_if[i].wlast;
        assign wr_data_rdy[i] = wr_if[i].wready;

        cnn_axi_wr_bridge u_wr_bridge (
            .clk     (clk),
            .rst     (rst),
            .wr      (wr_if[i]),
            .wr_cmpl (wr_cmpl[i])
        );
    end

endmodule

// ==== rtl/cnn_axi_wr_bridge.sv ====
module cnn_axi_wr_bridge (
    input  logic      clk,
    input  logic      rst,
    axi_wr_if.bridge  wr,
    output logic      wr_cmpl      // Write response seen
);

    ////////////////////
    // Handshakes
    ////////////////////
    logic aw_hs;                   // Burst accepted by the slave
    logic w_hs;                    // Data beat accepted by the slave
    logic beat_hs;                 // Data beat that belongs to the tracked burst

    assign aw_hs = wr.awvalid & wr.awready;
    assign w_hs  = wr.wvalid & wr.wready;

    ////////////////////
    // Burst tracker
    ////////////////////
    // Armed from the AW transfer until the response comes back
    // Beats before arming still go out but are not counted

    logic               armed;     // Burst open
    cnn_axi_pkg::len_t  len_q;     // awlen of the open burst
    cnn_axi_pkg::len_t  beat_cnt;  // Beats sent so far in the open burst

    assign beat_hs = armed & w_hs;

    // Arm flag
    always_ff @(posedge clk) begin
        if (rst) begin
            armed <= 1'b0;
        end else begin
            if (wr.bvalid) begin
                armed <= 1'b0;        // Response closes the burst
            end
            if (aw_hs) begin
                armed <= 1'b1;        // New burst wins over a same cycle response
            end
        end
    end

    // Burst length captured with the address
    always_ff @(posedge clk) begin
        if (aw_hs) begin
            len_q <= wr.awlen;
        end
    end

    // Beat counter
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
        end else begin
            if (wr.bvalid) begin
                beat_cnt <= '0;                       // Clear for the next burst
            end else if (beat_hs) begin
                beat_cnt <= beat_cnt + 1'b1;          // Holds while wready is low
            end
            if (aw_hs) begin
                beat_cnt <= '0;                       // Start from the first beat
            end
        end
    end

    ////////////////////
    // wlast and completion
    ////////////////////
    // Last beat is the one whose index equals the stored length
    // since awlen already holds beats minus one
    assign wr.wlast = armed & (beat_cnt == len_q);

    // bready is tied high at the slave, so bvalid is the response
    assign wr_cmpl = wr.bvalid;

endmodule

// ==== rtl/cnn_axi_rd_bridge.sv ====
module cnn_axi_rd_bridge (
    input  logic                                   clk,
    input  logic                                   rst,
    axi_rd_if.bridge                               rd [cnn_axi_pkg::NUM_RD_CLIENTS],
    output logic [cnn_axi_pkg::NUM_RD_CLIENTS-1:0] rd_cmpl   // One pulse per finished burst
);

    ////////////////////
    // Last beat detect
    ////////////////////
    // AR and R fields go client to slave untouched in the top level
    // Only the end of each burst is picked up here

    logic [cnn_axi_pkg::NUM_RD_CLIENTS-1:0] r_hs;      // Beat accepted this cycle
    logic [cnn_axi_pkg::NUM_RD_CLIENTS-1:0] last_hs;   // Final beat accepted

    for (genvar i = 0; i < cnn_axi_pkg::NUM_RD_CLIENTS; i++) begin : g_client
        // Transfer needs both sides
        assign r_hs[i] = rd[i].rvalid & rd[i].rready;

        // rlast alone is not enough, a stalled last beat must wait
        assign last_hs[i] = r_hs[i] & rd[i].rlast;
    end

    ////////////////////
    // Completion pulse
    ////////////////////
    // Each client has its own R channel, so no ID
    // matching is needed to steer the pulse

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_cmpl <= '0;            // Nothing in flight after reset
        end else begin
            rd_cmpl <= last_hs;       // High for one cycle, then drops
        end
    end

    // A new last beat in the very next cycle gives back-to-back pulses
    // The client sees one pulse per burst either way

endmodule

// ==== rtl/cnn_axi_if.sv ====
// Read side of one client, AR and R channels
interface axi_rd_if;
    // AR channel
    logic                arvalid;  // Client request maps straight onto this
    logic                arready;
    cnn_axi_pkg::addr_t  araddr;
    cnn_axi_pkg::id_t    arid;
    cnn_axi_pkg::len_t   arlen;    // Beats minus one
    // R channel
    logic                rvalid;
    logic                rready;   // Client data ready
    cnn_axi_pkg::data_t  rdata;
    logic                rlast;

    // Bridge only watches the channel
    modport bridge (
        input arvalid, arready, araddr, arid, arlen,
        input rvalid, rready, rdata, rlast
    );

    // Top level fills every field from its plain ports
    modport port (
        output arvalid, arready, araddr, arid, arlen,
        output rvalid, rready, rdata, rlast
    );
endinterface

// Write side of one client, AW W and B channels
interface axi_wr_if;
    // AW channel
    logic                awvalid;
    logic                awready;
    cnn_axi_pkg::addr_t  awaddr;
    cnn_axi_pkg::id_t    awid;
    cnn_axi_pkg::len_t   awlen;
    // W channel
    logic                wvalid;
    logic                wready;
    cnn_axi_pkg::data_t  wdata;
    logic                wlast;    // Generated in the bridge
    // B channel
    logic                bvalid;

    modport bridge (
        input  awvalid, awready, awaddr, awid, awlen,
        input  wvalid, wready, wdata, bvalid,
        output wlast
    );

    modport port (
        output awvalid, awready, awaddr, awid, awlen,
        output wvalid, wready, wdata, bvalid,
        input  wlast
    );
endinterface

// ==== rtl/cnn_axi_pkg.sv ====
package cnn_axi_pkg;

    ////////////////////
    // Client counts
    ////////////////////
    localparam int NUM_RD_CLIENTS = 2;  // Read masters on the accelerator side
    localparam int NUM_WR_CLIENTS = 2;  // Write masters on the accelerator side

    ////////////////////
    // Fixed AXI attributes
    ////////////////////
    // The slave is assumed to take these without the ports carrying them
    localparam int AXI_SIZE_8B    = 3;  // 8 byte beats
    localparam int AXI_BURST_INCR = 1;  // INCR bursts only
    // Strobes are taken as all ones and bready as always high

    ////////////////////
    // Field widths
    ////////////////////
    localparam int ADDR_W = 32;
    localparam int ID_W   = 4;
    localparam int LEN_W  = 8;                  // Beat count minus one
    localparam int DATA_W = 8 << AXI_SIZE_8B;   // One full beat in bits

    ////////////////////
    // Field types
    ////////////////////
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [ID_W-1:0]   id_t;
    typedef logic [LEN_W-1:0]  len_t;  // Also sized for the beat counter
    typedef logic [DATA_W-1:0] data_t;

endpackage
